// File: hdl/cp0_params.svh
`ifndef CP0_PARAMS_SVH
`define CP0_PARAMS_SVH

// general exception entry with BEV set
`define EXC_VECTOR          32'hbfc0_0380

// only BEV (bit 22) is set out of reset
`define CP0_STATUS_RESET    32'h0040_0000

`define CP0_REG_BADVADDR    5'd8
`define CP0_REG_COUNT       5'd9
`define CP0_REG_COMPARE     5'd11
`define CP0_REG_STATUS      5'd12
`define CP0_REG_CAUSE       5'd13
`define CP0_REG_EPC         5'd14

`endif

// File: hdl/cp0_pkg.sv
`default_nettype none

package cp0_pkg;

    import exc_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Status, register 12
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [8:0] rsvd_31_23;
        logic       bev;
        logic [5:0] rsvd_21_16;
        logic [7:0] im;
        logic [5:0] rsvd_7_2;
        logic       exl;
        logic       ie;
    } cp0_status_t;

    // mtc0/mfc0 see the raw word, the hardware works on the fields
    typedef union packed {
        logic [31:0] word;
        cp0_status_t f;
    } cp0_status_u;

    ////////////////////////////////////////////////////////////////////////////
    // Cause, register 13
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic       bd;
        logic       ti;
        logic [13:0] rsvd_29_16;
        logic [7:0] ip;
        logic       rsvd_7;
        exccode_e   exccode;
        logic [1:0] rsvd_1_0;
    } cp0_cause_t;

    typedef union packed {
        logic [31:0] word;
        cp0_cause_t  f;
    } cp0_cause_u;

endpackage

`default_nettype wire

// File: hdl/cp0_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "cp0_params.svh"

module cp0_regs
    import exc_pkg::*;
    import cp0_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        exc_update_ena,
    input  exccode_e    exc_code,
    input  logic        exc_bd,
    input  logic [31:0] exc_epc,
    input  logic        badvaddr_ena,
    input  logic [31:0] badvaddr,
    input  logic        eret_clear_exl,

    input  logic [5:0]  hw_ip,

    input  logic        cp0_wen,
    input  logic [4:0]  cp0_waddr,
    input  logic [31:0] cp0_wdata,
    input  logic [4:0]  cp0_raddr,
    output logic [31:0] cp0_rdata,

    output cp0_status_u status_word,
    output cp0_cause_u  cause_word,
    output logic [31:0] epc_value
);

    cp0_status_u status_q;
    cp0_cause_u  cause_q;
    logic [31:0] epc_q;
    logic [31:0] badvaddr_q;
    logic [31:0] count_q;
    logic [31:0] compare_q;
    // Count and Compare both leave reset at zero, so matching waits for a Compare write
    logic        timer_armed;

    cp0_status_u wdata_status;
    cp0_cause_u  wdata_cause;
    logic        wr_status;
    logic        wr_cause;
    logic        wr_epc;
    logic        wr_count;
    logic        wr_compare;

    assign wdata_status = cp0_wdata;
    assign wdata_cause  = cp0_wdata;

    assign wr_status  = cp0_wen && (cp0_waddr == `CP0_REG_STATUS);
    assign wr_cause   = cp0_wen && (cp0_waddr == `CP0_REG_CAUSE);
    assign wr_epc     = cp0_wen && (cp0_waddr == `CP0_REG_EPC);
    assign wr_count   = cp0_wen && (cp0_waddr == `CP0_REG_COUNT);
    assign wr_compare = cp0_wen && (cp0_waddr == `CP0_REG_COMPARE);

    ////////////////////////////////////////////////////////////////////////////
    // register update, exception side is applied last so it wins
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_q    <= `CP0_STATUS_RESET;
            cause_q     <= '0;
            epc_q       <= '0;
            badvaddr_q  <= '0;
            count_q     <= '0;
            compare_q   <= '0;
            timer_armed <= 1'b0;
        end else begin
            if (wr_status) begin
                status_q.f.im  <= wdata_status.f.im;
                status_q.f.exl <= wdata_status.f.exl;
                status_q.f.ie  <= wdata_status.f.ie;
            end
            if (wr_cause) begin
                cause_q.f.ip[1:0] <= wdata_cause.f.ip[1:0];
            end
            if (wr_epc) begin
                epc_q <= cp0_wdata;
            end

            count_q <= wr_count ? cp0_wdata : count_q + 32'd1;

            // moving Compare acknowledges the timer interrupt
            if (wr_compare) begin
                compare_q    <= cp0_wdata;
                timer_armed  <= 1'b1;
                cause_q.f.ti <= 1'b0;
            end else if (timer_armed && (count_q == compare_q)) begin
                cause_q.f.ti <= 1'b1;
            end

            if (exc_update_ena) begin
                status_q.f.exl     <= 1'b1;
                cause_q.f.bd       <= exc_bd;
                cause_q.f.exccode  <= exc_code;
                epc_q              <= exc_epc;
            end
            if (badvaddr_ena) begin
                badvaddr_q <= badvaddr;
            end
            if (eret_clear_exl) begin
                status_q.f.exl <= 1'b0;
            end
        end
    end

    // hardware lines are live in IP[7:2], TI shares IP[7] with line 5
    always_comb begin
        cause_word = cause_q;
        cause_word.f.ip[7:2] = {hw_ip[5] | cause_q.f.ti, hw_ip[4:0]};
    end

    assign status_word = status_q;
    assign epc_value   = epc_q;

    always_comb begin
        case (cp0_raddr)
            `CP0_REG_BADVADDR: cp0_rdata = badvaddr_q;
            `CP0_REG_COUNT:    cp0_rdata = count_q;
            `CP0_REG_COMPARE:  cp0_rdata = compare_q;
            `CP0_REG_STATUS:   cp0_rdata = status_q.word;
            `CP0_REG_CAUSE:    cp0_rdata = cause_word.word;
            `CP0_REG_EPC:      cp0_rdata = epc_q;
            default:           cp0_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/exc_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// exception codes as written into Cause.ExcCode
////////////////////////////////////////////////////////////////////////////

package exc_pkg;

    typedef enum logic [4:0] {
        EXC_INT  = 5'h00,
        // address error on load or instruction fetch
        EXC_ADEL = 5'h04,
        // address error on store
        EXC_ADES = 5'h05,
        EXC_SYS  = 5'h08,
        EXC_BP   = 5'h09,
        // reserved instruction
        EXC_RI   = 5'h0a,
        // arithmetic overflow
        EXC_OV   = 5'h0c
    } exccode_e;

endpackage

`default_nettype wire

// File: hdl/exc_unit_top.sv
`timescale 1ns/100ps
`default_nettype none

module exc_unit_top
    import exc_pkg::*;
    import cp0_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic [31:0] pc_1,
    input  logic [31:0] mem_badvaddr_1,
    input  logic        in_delay_slot_1,
    input  logic        exc_eret_1,
    input  logic        exc_syscall_1,
    input  logic        exc_break_1,
    input  logic        exc_inst_adel_1,
    input  logic        exc_data_adel_1,
    input  logic        exc_data_ades_1,
    input  logic        exc_overflow_1,
    input  logic        exc_ri_1,

    input  logic [31:0] pc_2,
    input  logic [31:0] mem_badvaddr_2,
    input  logic        in_delay_slot_2,
    input  logic        exc_eret_2,
    input  logic        exc_syscall_2,
    input  logic        exc_break_2,
    input  logic        exc_inst_adel_2,
    input  logic        exc_data_adel_2,
    input  logic        exc_data_ades_2,
    input  logic        exc_overflow_2,
    input  logic        exc_ri_2,

    input  logic        inst_valid_1,
    input  logic [5:0]  hw_int,

    input  logic        cp0_wen,
    input  logic [4:0]  cp0_waddr,
    input  logic [31:0] cp0_wdata,
    input  logic [4:0]  cp0_raddr,

    output logic        exception_pc_ena,
    output logic [31:0] exception_pc,
    output logic        flush_pipeline,
    output logic [31:0] cp0_rdata
);

    logic        int_pending;
    logic [5:0]  hw_ip;
    cp0_status_u status_word;
    cp0_cause_u  cause_word;
    logic [31:0] epc_value;

    logic        exc_update_ena;
    exccode_e    exc_code;
    logic        exc_bd;
    logic [31:0] exc_epc;
    logic        badvaddr_ena;
    logic [31:0] badvaddr;
    logic        eret_clear_exl;

    // port names line up across the three blocks
    interrupt_detect i_interrupt_detect (.*);

    exception_ctrl i_exception_ctrl (.*);

    cp0_regs i_cp0_regs (.*);

endmodule

`default_nettype wire

// File: hdl/exception_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "cp0_params.svh"

module exception_ctrl
    import exc_pkg::*;
(
    // commit slot 1, the older instruction
    input  logic [31:0] pc_1,
    input  logic [31:0] mem_badvaddr_1,
    input  logic        in_delay_slot_1,
    input  logic        exc_eret_1,
    input  logic        exc_syscall_1,
    input  logic        exc_break_1,
    input  logic        exc_inst_adel_1,
    input  logic        exc_data_adel_1,
    input  logic        exc_data_ades_1,
    input  logic        exc_overflow_1,
    input  logic        exc_ri_1,

    // commit slot 2
    input  logic [31:0] pc_2,
    input  logic [31:0] mem_badvaddr_2,
    input  logic        in_delay_slot_2,
    input  logic        exc_eret_2,
    input  logic        exc_syscall_2,
    input  logic        exc_break_2,
    input  logic        exc_inst_adel_2,
    input  logic        exc_data_adel_2,
    input  logic        exc_data_ades_2,
    input  logic        exc_overflow_2,
    input  logic        exc_ri_2,

    input  logic        inst_valid_1,
    input  logic        int_pending,
    input  logic [31:0] epc_value,

    output logic        exception_pc_ena,
    output logic [31:0] exception_pc,
    output logic        flush_pipeline,

    output logic        exc_update_ena,
    output exccode_e    exc_code,
    output logic        exc_bd,
    output logic [31:0] exc_epc,
    output logic        badvaddr_ena,
    output logic [31:0] badvaddr,
    output logic        eret_clear_exl
);

    // flag vectors are ordered by priority, highest at the top
    localparam int F_INST_ADEL = 7;
    localparam int F_RI        = 6;
    localparam int F_OV        = 5;
    localparam int F_SYS       = 4;
    localparam int F_BP        = 3;
    localparam int F_ERET      = 2;
    localparam int F_DATA_ADEL = 1;
    localparam int F_DATA_ADES = 0;

    logic [7:0]  flags_1;
    logic [7:0]  flags_2;
    logic        take_int;
    logic        use_slot_2;
    logic [7:0]  sel_flags;
    logic [31:0] sel_pc;
    logic [31:0] sel_mem_badvaddr;
    logic        sel_ds;

    assign flags_1 = {exc_inst_adel_1, exc_ri_1, exc_overflow_1, exc_syscall_1,
                      exc_break_1, exc_eret_1, exc_data_adel_1, exc_data_ades_1};
    assign flags_2 = {exc_inst_adel_2, exc_ri_2, exc_overflow_2, exc_syscall_2,
                      exc_break_2, exc_eret_2, exc_data_adel_2, exc_data_ades_2};

    // an interrupt needs a real instruction in slot 1 to carry its EPC
    assign take_int   = int_pending && inst_valid_1;
    assign use_slot_2 = !take_int && !(|flags_1);

    assign sel_flags        = use_slot_2 ? flags_2        : flags_1;
    assign sel_pc           = use_slot_2 ? pc_2           : pc_1;
    assign sel_mem_badvaddr = use_slot_2 ? mem_badvaddr_2 : mem_badvaddr_1;
    assign sel_ds           = use_slot_2 ? in_delay_slot_2 : in_delay_slot_1;

    always_comb begin
        exception_pc_ena = 1'b0;
        exception_pc     = '0;
        exc_update_ena   = 1'b0;
        exc_code         = EXC_INT;
        exc_bd           = 1'b0;
        exc_epc          = '0;
        badvaddr_ena     = 1'b0;
        badvaddr         = '0;
        eret_clear_exl   = 1'b0;

        if (take_int || (|sel_flags)) begin
            exception_pc_ena = 1'b1;
            exception_pc     = `EXC_VECTOR;
            exc_update_ena   = 1'b1;
            exc_bd           = sel_ds;
            // a faulting delay slot restarts at its branch
            exc_epc          = sel_ds ? sel_pc - 32'd4 : sel_pc;

            if (take_int) begin
                exc_code = EXC_INT;
            end else if (sel_flags[F_INST_ADEL]) begin
                exc_code     = EXC_ADEL;
                badvaddr_ena = 1'b1;
                badvaddr     = sel_pc;
            end else if (sel_flags[F_RI]) begin
                exc_code = EXC_RI;
            end else if (sel_flags[F_OV]) begin
                exc_code = EXC_OV;
            end else if (sel_flags[F_SYS]) begin
                exc_code = EXC_SYS;
            end else if (sel_flags[F_BP]) begin
                exc_code = EXC_BP;
            end else if (sel_flags[F_ERET]) begin
                // return from handler, Cause and EPC stay as they are
                exc_update_ena = 1'b0;
                eret_clear_exl = 1'b1;
                exception_pc   = epc_value;
            end else if (sel_flags[F_DATA_ADEL]) begin
                exc_code     = EXC_ADEL;
                badvaddr_ena = 1'b1;
                badvaddr     = sel_mem_badvaddr;
            end else begin
                exc_code     = EXC_ADES;
                badvaddr_ena = 1'b1;
                badvaddr     = sel_mem_badvaddr;
            end
        end
    end

    assign flush_pipeline = exception_pc_ena;

endmodule

`default_nettype wire

// File: hdl/interrupt_detect.sv
`timescale 1ns/100ps
`default_nettype none

module interrupt_detect
    import cp0_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [5:0]  hw_int,
    input  cp0_status_u status_word,
    input  cp0_cause_u  cause_word,
    output logic [5:0]  hw_ip,
    output logic        int_pending
);

    logic [5:0] sync_ff1;
    logic [5:0] sync_ff2;
    logic [7:0] ip_masked;

    // the external lines are asynchronous to clk, two flops before use
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_ff1 <= '0;
            sync_ff2 <= '0;
        end else begin
            sync_ff1 <= hw_int;
            sync_ff2 <= sync_ff1;
        end
    end

    assign hw_ip = sync_ff2;

    // cause_word already carries hw_ip and TI in IP[7:2] and the software bits in IP[1:0]
    assign ip_masked = cause_word.f.ip & status_word.f.im;

    // no nesting while EXL is set
    assign int_pending = (|ip_masked) && status_word.f.ie && !status_word.f.exl;

endmodule

`default_nettype wire

// File: tb.f
+incdir+hdl
hdl/exc_pkg.sv
hdl/cp0_pkg.sv
hdl/interrupt_detect.sv
hdl/exception_ctrl.sv
hdl/cp0_regs.sv
hdl/exc_unit_top.sv
tb/tb_exc_unit.sv

// File: tb/tb_exc_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "cp0_params.svh"

module tb_exc_unit
    import exc_pkg::*;
();

    localparam int RANDOM_ROUNDS  = 300;
    // four cycles per random round plus about a hundred for the directed tests
    localparam int TIMEOUT_CYCLES = (RANDOM_ROUNDS * 4 + 100) * 3 / 2;

    logic        clk;
    logic        rst_n;
    logic [31:0] s_pc    [1:2];
    logic [31:0] s_bad   [1:2];
    logic        s_ds    [1:2];
    logic        s_eret  [1:2];
    logic        s_sys   [1:2];
    logic        s_bp    [1:2];
    logic        s_iadel [1:2];
    logic        s_dadel [1:2];
    logic        s_dades [1:2];
    logic        s_ov    [1:2];
    logic        s_ri    [1:2];
    logic        inst_valid_1;
    logic [5:0]  hw_int;
    logic        cp0_wen;
    logic [4:0]  cp0_waddr;
    logic [31:0] cp0_wdata;
    logic [4:0]  cp0_raddr;
    logic        exception_pc_ena;
    logic [31:0] exception_pc;
    logic        flush_pipeline;
    logic [31:0] cp0_rdata;

    // reference model state
    logic [7:0]  m_im;
    logic        m_exl;
    logic        m_ie;
    logic [1:0]  m_sw_ip;
    logic        m_ti;
    logic        m_bd;
    logic [4:0]  m_exccode;
    logic [31:0] m_epc;
    logic [31:0] m_badvaddr;
    logic [31:0] m_count;
    logic [31:0] m_compare;
    logic        m_armed;
    logic [5:0]  m_sync;
    logic [5:0]  m_hw;
    logic        exp_ena;
    logic [31:0] exp_pc;

    logic [31:0] lfsr_state;
    logic [31:0] exp_word;
    logic [31:0] rnd;
    int          cycle_count;

    exc_unit_top i_exc_unit_top (
        .clk(clk), .rst_n(rst_n),
        .pc_1(s_pc[1]), .mem_badvaddr_1(s_bad[1]), .in_delay_slot_1(s_ds[1]),
        .exc_eret_1(s_eret[1]), .exc_syscall_1(s_sys[1]), .exc_break_1(s_bp[1]),
        .exc_inst_adel_1(s_iadel[1]), .exc_data_adel_1(s_dadel[1]),
        .exc_data_ades_1(s_dades[1]), .exc_overflow_1(s_ov[1]), .exc_ri_1(s_ri[1]),
        .pc_2(s_pc[2]), .mem_badvaddr_2(s_bad[2]), .in_delay_slot_2(s_ds[2]),
        .exc_eret_2(s_eret[2]), .exc_syscall_2(s_sys[2]), .exc_break_2(s_bp[2]),
        .exc_inst_adel_2(s_iadel[2]), .exc_data_adel_2(s_dadel[2]),
        .exc_data_ades_2(s_dades[2]), .exc_overflow_2(s_ov[2]), .exc_ri_2(s_ri[2]),
        .inst_valid_1(inst_valid_1), .hw_int(hw_int),
        .cp0_wen(cp0_wen), .cp0_waddr(cp0_waddr), .cp0_wdata(cp0_wdata),
        .cp0_raddr(cp0_raddr),
        .exception_pc_ena(exception_pc_ena), .exception_pc(exception_pc),
        .flush_pipeline(flush_pipeline), .cp0_rdata(cp0_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run("timeout: the tests did not finish in the expected number of cycles");
        end
    end

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        assert (act === exp)
        else begin
            fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus comes from a Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // three bits ANDed, so slot 1 is often free and slot 2 gets its turn
    task automatic take_flag(output logic f);
        logic [31:0] v;
        take_bits(3, v);
        f = &v[2:0];
    endtask

    task automatic idle_slots();
        for (int k = 1; k <= 2; k++) begin
            s_pc[k]    = '0;
            s_bad[k]   = '0;
            s_ds[k]    = 1'b0;
            s_eret[k]  = 1'b0;
            s_sys[k]   = 1'b0;
            s_bp[k]    = 1'b0;
            s_iadel[k] = 1'b0;
            s_dadel[k] = 1'b0;
            s_dades[k] = 1'b0;
            s_ov[k]    = 1'b0;
            s_ri[k]    = 1'b0;
        end
    endtask

    task automatic random_slots();
        logic [31:0] v;
        for (int k = 1; k <= 2; k++) begin
            take_bits(32, v);
            s_pc[k] = v;
            take_bits(32, v);
            s_bad[k] = v;
            take_bits(1, v);
            s_ds[k] = v[0];
            take_flag(s_eret[k]);
            take_flag(s_sys[k]);
            take_flag(s_bp[k]);
            take_flag(s_iadel[k]);
            take_flag(s_dadel[k]);
            take_flag(s_dades[k]);
            take_flag(s_ov[k]);
            take_flag(s_ri[k]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [7:0] model_ip();
        return {m_hw[5] | m_ti, m_hw[4:0], m_sw_ip};
    endfunction

    function automatic logic interrupt_due();
        return (|(model_ip() & m_im)) && m_ie && !m_exl;
    endfunction

    function automatic logic [31:0] expected_status();
        return `CP0_STATUS_RESET | {16'h0, m_im, 6'h0, m_exl, m_ie};
    endfunction

    function automatic logic [31:0] expected_cause();
        return {m_bd, m_ti, 14'h0, model_ip(), 1'b0, m_exccode, 2'b00};
    endfunction

    task automatic enter_exception(input int k, input logic [4:0] code);
        exp_ena   = 1'b1;
        exp_pc    = `EXC_VECTOR;
        m_exl     = 1'b1;
        m_bd      = s_ds[k];
        m_exccode = code;
        m_epc     = s_ds[k] ? s_pc[k] - 32'd4 : s_pc[k];
    endtask

    task automatic model_event();
        logic done;
        exp_ena = 1'b0;
        exp_pc  = '0;
        done    = 1'b0;
        if (interrupt_due() && inst_valid_1) begin
            enter_exception(1, EXC_INT);
            done = 1'b1;
        end
        for (int k = 1; k <= 2; k++) begin
            if (!done) begin
                done = 1'b1;
                if (s_iadel[k]) begin
                    enter_exception(k, EXC_ADEL);
                    m_badvaddr = s_pc[k];
                end else if (s_ri[k]) begin
                    enter_exception(k, EXC_RI);
                end else if (s_ov[k]) begin
                    enter_exception(k, EXC_OV);
                end else if (s_sys[k]) begin
                    enter_exception(k, EXC_SYS);
                end else if (s_bp[k]) begin
                    enter_exception(k, EXC_BP);
                end else if (s_eret[k]) begin
                    exp_ena = 1'b1;
                    exp_pc  = m_epc;
                    m_exl   = 1'b0;
                end else if (s_dadel[k]) begin
                    enter_exception(k, EXC_ADEL);
                    m_badvaddr = s_bad[k];
                end else if (s_dades[k]) begin
                    enter_exception(k, EXC_ADES);
                    m_badvaddr = s_bad[k];
                end else begin
                    done = 1'b0;
                end
            end
        end
    endtask

    task automatic apply_mtc0(input logic [4:0] addr, input logic [31:0] data);
        case (addr)
            `CP0_REG_STATUS: begin
                m_im  = data[15:8];
                m_exl = data[1];
                m_ie  = data[0];
            end
            `CP0_REG_CAUSE: m_sw_ip = data[9:8];
            `CP0_REG_EPC:   m_epc = data;
            default: ;
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // each cycle drives inputs at the falling edge and checks just after it
    ////////////////////////////////////////////////////////////////////////////

    task automatic begin_cycle();
        @(negedge clk);
        idle_slots();
        inst_valid_1 = 1'b0;
        cp0_wen      = 1'b0;
    endtask

    task automatic end_cycle(input string name);
        #0.1;
        model_event();
        compare_value({name, " redirect"}, exp_ena, exception_pc_ena);
        compare_value({name, " flush"}, exp_ena, flush_pipeline);
        if (exp_ena) begin
            compare_value({name, " target"}, exp_pc, exception_pc);
        end
        if (cp0_wen) begin
            apply_mtc0(cp0_waddr, cp0_wdata);
        end
        // Compare only starts matching once it has been written after reset
        if (cp0_wen && cp0_waddr == `CP0_REG_COMPARE) begin
            m_compare = cp0_wdata;
            m_armed   = 1'b1;
            m_ti      = 1'b0;
        end else if (m_armed && m_count == m_compare) begin
            m_ti = 1'b1;
        end
        m_count = m_count + 32'd1;
        m_hw    = m_sync;
        m_sync  = hw_int;
    endtask

    task automatic mtc0_write(input logic [4:0] addr, input logic [31:0] data);
        begin_cycle();
        cp0_wen   = 1'b1;
        cp0_waddr = addr;
        cp0_wdata = data;
        end_cycle("mtc0");
    endtask

    task automatic mfc0_check(input string name, input logic [4:0] addr,
                              input logic [31:0] exp);
        begin_cycle();
        cp0_raddr = addr;
        end_cycle(name);
        compare_value(name, exp, cp0_rdata);
    endtask

    task automatic verify_event_regs(input string name);
        mfc0_check({name, " cause"}, `CP0_REG_CAUSE, expected_cause());
        mfc0_check({name, " epc"}, `CP0_REG_EPC, m_epc);
        mfc0_check({name, " badvaddr"}, `CP0_REG_BADVADDR, m_badvaddr);
    endtask

    initial begin
        rst_n        = 1'b0;
        inst_valid_1 = 1'b0;
        hw_int       = '0;
        cp0_wen      = 1'b0;
        cp0_waddr    = '0;
        cp0_wdata    = '0;
        cp0_raddr    = '0;
        idle_slots();
        lfsr_state  = 32'd56;
        cycle_count = 0;
        m_im        = '0;
        m_exl       = 1'b0;
        m_ie        = 1'b0;
        m_sw_ip     = '0;
        m_ti        = 1'b0;
        m_bd        = 1'b0;
        m_exccode   = '0;
        m_epc       = '0;
        m_badvaddr  = '0;
        m_count     = '0;
        m_compare   = '0;
        m_armed     = 1'b0;
        m_sync      = '0;
        m_hw        = '0;

        repeat (3) @(posedge clk);
        begin_cycle();
        rst_n = 1'b1;
        end_cycle("reset release");

        mfc0_check("reset status", `CP0_REG_STATUS, `CP0_STATUS_RESET);
        mfc0_check("reset cause", `CP0_REG_CAUSE, 32'h0);
        mfc0_check("reset epc", `CP0_REG_EPC, 32'h0);
        mfc0_check("reset badvaddr", `CP0_REG_BADVADDR, 32'h0);
        mfc0_check("reset compare", `CP0_REG_COMPARE, 32'h0);

        // interrupts stay masked here because IE is clear from reset
        for (int r = 0; r < RANDOM_ROUNDS; r++) begin
            exp_word = expected_status();
            begin_cycle();
            random_slots();
            take_bits(1, rnd);
            inst_valid_1 = rnd[0];
            cp0_raddr    = `CP0_REG_STATUS;
            end_cycle("random flags");
            compare_value("random status", exp_word, cp0_rdata);
            verify_event_regs("random flags");
        end

        ////////////////////////////////////////////////////////////////////////////
        // address errors and eret
        ////////////////////////////////////////////////////////////////////////////

        begin_cycle();
        s_iadel[1] = 1'b1;
        s_pc[1]    = 32'h0040_0001;
        end_cycle("inst adel");
        verify_event_regs("inst adel");

        begin_cycle();
        s_dadel[2] = 1'b1;
        s_pc[2]    = 32'h0040_0104;
        s_bad[2]   = 32'h1000_0003;
        end_cycle("data adel");
        verify_event_regs("data adel");

        begin_cycle();
        s_dades[1] = 1'b1;
        s_ds[1]    = 1'b1;
        s_pc[1]    = 32'h0040_0208;
        s_bad[1]   = 32'h1000_0006;
        end_cycle("data ades");
        verify_event_regs("data ades");

        begin_cycle();
        s_ov[2] = 1'b1;
        s_pc[2] = 32'h0040_0300;
        s_bad[2] = 32'hdead_0000;
        end_cycle("overflow");
        verify_event_regs("overflow");

        mtc0_write(`CP0_REG_STATUS, 32'h0000_0002);
        mtc0_write(`CP0_REG_EPC, 32'h8000_1234);
        begin_cycle();
        s_eret[1] = 1'b1;
        end_cycle("eret");
        compare_value("eret target", 32'h8000_1234, exception_pc);
        mfc0_check("eret status", `CP0_REG_STATUS, expected_status());
        verify_event_regs("eret");

        ////////////////////////////////////////////////////////////////////////////
        // software interrupt and masking
        ////////////////////////////////////////////////////////////////////////////

        mtc0_write(`CP0_REG_STATUS, 32'h0000_0101);
        mtc0_write(`CP0_REG_CAUSE, 32'h0000_0100);
        begin_cycle();
        end_cycle("interrupt without valid slot");
        compare_value("interrupt without valid slot", 32'h0, exception_pc_ena);

        begin_cycle();
        inst_valid_1 = 1'b1;
        s_pc[1]      = 32'h8000_0100;
        s_ds[1]      = 1'b1;
        s_sys[1]     = 1'b1;
        s_ri[2]      = 1'b1;
        end_cycle("software interrupt");
        compare_value("software interrupt taken", 32'h1, exception_pc_ena);
        verify_event_regs("software interrupt");

        begin_cycle();
        inst_valid_1 = 1'b1;
        end_cycle("interrupt under exl");
        compare_value("interrupt under exl", 32'h0, exception_pc_ena);

        mtc0_write(`CP0_REG_STATUS, 32'h0000_0100);
        begin_cycle();
        inst_valid_1 = 1'b1;
        end_cycle("interrupt with ie clear");
        compare_value("interrupt with ie clear", 32'h0, exception_pc_ena);
        mtc0_write(`CP0_REG_CAUSE, 32'h0);

        ////////////////////////////////////////////////////////////////////////////
        // hardware line and timer
        ////////////////////////////////////////////////////////////////////////////

        mtc0_write(`CP0_REG_STATUS, 32'h0000_0401);
        begin_cycle();
        hw_int       = 6'b00_0001;
        inst_valid_1 = 1'b1;
        end_cycle("hw line edge 0");
        compare_value("hw line edge 0", 32'h0, exception_pc_ena);
        begin_cycle();
        inst_valid_1 = 1'b1;
        end_cycle("hw line edge 1");
        compare_value("hw line edge 1", 32'h0, exception_pc_ena);
        begin_cycle();
        inst_valid_1 = 1'b1;
        s_pc[1]      = 32'h8000_0200;
        end_cycle("hw line edge 2");
        compare_value("hw interrupt taken", 32'h1, exception_pc_ena);
        begin_cycle();
        hw_int = '0;
        end_cycle("hw line low");
        verify_event_regs("hw interrupt");

        mfc0_check("count", `CP0_REG_COUNT, m_count);
        mtc0_write(`CP0_REG_COMPARE, m_count + 32'd20);
        for (int i = 0; i < 24; i++) begin
            mfc0_check("timer cause", `CP0_REG_CAUSE, expected_cause());
        end
        // the last read comes after Count reached Compare
        compare_value("timer ti", 32'h1, cp0_rdata[30]);

        mtc0_write(`CP0_REG_STATUS, 32'h0000_8001);
        begin_cycle();
        inst_valid_1 = 1'b1;
        s_pc[1]      = 32'h8000_0300;
        end_cycle("timer interrupt");
        compare_value("timer interrupt taken", 32'h1, exception_pc_ena);
        verify_event_regs("timer interrupt");
        mtc0_write(`CP0_REG_COMPARE, m_count + 32'd1000);
        mfc0_check("ti cleared", `CP0_REG_CAUSE, expected_cause());

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire
